// File: design/beam_tx_macros.svh
`ifndef BEAM_TX_MACROS_SVH
`define BEAM_TX_MACROS_SVH

// Transducer array
`define BTX_NUM_ELEMENTS 16
`define BTX_HALF_ELEMENTS 8

// Field widths with a signed step in 1/16 sample units
`define BTX_DW_R0 8
`define BTX_DW_STEP 8
`define BTX_DW_POINTS 13
`define BTX_DW_FRAC 4
`define BTX_DW_DELAY 17

// Idle cycles between two transmissions of a scanline
`define BTX_TX_GAP 4

// APB register map
`define BTX_ADDR_CFG 4'h0
`define BTX_ADDR_POINTS 4'h4
`define BTX_ADDR_CTRL 4'h8
`define BTX_ADDR_STATUS 4'hC

`endif

// File: design/beam_tx_pkg.sv
`include "beam_tx_macros.svh"

package beam_tx_pkg;

    // APB request from the host
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [3:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // APB response to the host
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // Scanline configuration
    typedef struct packed {
        logic [`BTX_DW_R0-1:0]            r_0;
        logic signed [`BTX_DW_STEP-1:0]   step;
        logic [`BTX_DW_POINTS-1:0]        num_points;
    } scan_cfg_t;

    // Delay in samples, 4 fraction bits
    typedef logic [`BTX_DW_DELAY-1:0] delay_word_t;

    typedef delay_word_t [`BTX_NUM_ELEMENTS-1:0] delay_array_t;

    typedef struct packed {
        delay_word_t min_delay;
        delay_word_t max_delay;
    } delay_bounds_t;

endpackage

// File: design/apb_cfg_regs.sv
`timescale 1ns/1ns
`include "beam_tx_macros.svh"

module apb_cfg_regs (
    input  logic                    clk,
    input  logic                    rst,
    input  beam_tx_pkg::apb_req_t   apb_req,
    input  logic                    busy,
    input  logic                    scan_done,
    output beam_tx_pkg::apb_rsp_t   apb_rsp,
    output beam_tx_pkg::scan_cfg_t  cfg,
    output logic                    start
);

    logic access;
    logic wr_en;
    logic addr_hit;
    logic done_flag;

    assign access = apb_req.psel && apb_req.penable;
    assign wr_en  = access && apb_req.pwrite;

    always_comb begin
        case (apb_req.paddr)
            `BTX_ADDR_CFG,
            `BTX_ADDR_POINTS,
            `BTX_ADDR_CTRL,
            `BTX_ADDR_STATUS: addr_hit = 1'b1;
            default:          addr_hit = 1'b0;
        endcase
    end

    // Configuration registers
    always_ff @(posedge clk) begin
        if (rst) begin
            cfg <= '0;
        end else if (wr_en) begin
            case (apb_req.paddr)
                `BTX_ADDR_CFG: begin
                    cfg.r_0  <= apb_req.pwdata[`BTX_DW_R0-1:0];
                    cfg.step <= apb_req.pwdata[`BTX_DW_R0 +: `BTX_DW_STEP];
                end
                `BTX_ADDR_POINTS: cfg.num_points <= apb_req.pwdata[`BTX_DW_POINTS-1:0];
                default: ;
            endcase
        end
    end

    // Start pulse and sticky done
    always_ff @(posedge clk) begin
        if (rst) begin
            start     <= 1'b0;
            done_flag <= 1'b0;
        end else begin
            start <= wr_en && (apb_req.paddr == `BTX_ADDR_CTRL) && apb_req.pwdata[0] && !busy;
            if (start) begin
                done_flag <= 1'b0;
            end else if (scan_done) begin
                done_flag <= 1'b1;
            end
        end
    end

    always_comb begin
        apb_rsp         = '0;
        apb_rsp.pready  = 1'b1;   // Zero wait states
        apb_rsp.pslverr = access && !addr_hit;
        if (access && !apb_req.pwrite) begin
            case (apb_req.paddr)
                `BTX_ADDR_CFG:    apb_rsp.prdata = 32'({cfg.step, cfg.r_0});
                `BTX_ADDR_POINTS: apb_rsp.prdata = 32'(cfg.num_points);
                `BTX_ADDR_STATUS: apb_rsp.prdata = 32'({done_flag, busy});
                default:          apb_rsp.prdata = '0;   // CTRL reads as zero
            endcase
        end
    end

endmodule

// File: design/scan_sequencer.sv
`timescale 1ns/1ns
`include "beam_tx_macros.svh"

module scan_sequencer (
    input  logic                    clk,
    input  logic                    rst,
    input  beam_tx_pkg::scan_cfg_t  cfg,
    input  logic                    start,
    input  logic                    calc_done,
    input  logic                    tx_done,
    output logic                    calc_start,
    output logic                    tx_start,
    output logic                    busy,
    output logic                    scan_done
);

    localparam int PW    = `BTX_DW_POINTS;
    localparam int GAP_W = $clog2(`BTX_TX_GAP + 1);

    typedef enum logic [1:0] {
        st_idle,
        st_calc,
        st_transmit,
        st_gap
    } state_t;

    state_t            state;
    logic [PW-1:0]     points_q;
    logic [PW-1:0]     point_cnt;
    logic [GAP_W-1:0]  gap_cnt;

    assign busy = (state != st_idle);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= st_idle;
            points_q   <= '0;
            point_cnt  <= '0;
            gap_cnt    <= '0;
            calc_start <= 1'b0;
            tx_start   <= 1'b0;
            scan_done  <= 1'b0;
        end else begin
            calc_start <= 1'b0;
            tx_start   <= 1'b0;
            scan_done  <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        // Zero points behaves as one
                        points_q   <= (cfg.num_points == '0) ? PW'(1) : cfg.num_points;
                        point_cnt  <= PW'(1);
                        calc_start <= 1'b1;
                        state      <= st_calc;
                    end
                end
                st_calc: begin
                    if (calc_done) begin
                        tx_start <= 1'b1;
                        state    <= st_transmit;
                    end
                end
                st_transmit: begin
                    if (tx_done) begin
                        if (point_cnt == points_q) begin
                            scan_done <= 1'b1;
                            state     <= st_idle;
                        end else begin
                            point_cnt <= point_cnt + 1'b1;
                            gap_cnt   <= '0;
                            state     <= st_gap;
                        end
                    end
                end
                st_gap: begin
                    gap_cnt <= gap_cnt + 1'b1;
                    if (gap_cnt == GAP_W'(`BTX_TX_GAP - 1)) begin
                        tx_start <= 1'b1;   // Same pattern again
                        state    <= st_transmit;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// File: design/delay_calc.sv
`timescale 1ns/1ns
`include "beam_tx_macros.svh"

module delay_calc (
    input  logic                        clk,
    input  logic                        rst,
    input  beam_tx_pkg::scan_cfg_t      cfg,
    input  logic                        calc_start,
    output beam_tx_pkg::delay_array_t   delays,
    output beam_tx_pkg::delay_bounds_t  bounds,
    output logic                        calc_done
);

    import beam_tx_pkg::*;

    localparam int CENTRE = `BTX_HALF_ELEMENTS - 1;
    localparam int KW     = $clog2(`BTX_HALF_ELEMENTS + 1);
    localparam int AW     = `BTX_DW_DELAY + 3;   // Signed headroom

    logic [AW-1:0]                   n0_full;
    delay_word_t                     n0_q;
    logic signed [`BTX_DW_STEP-1:0]  step_q;
    logic signed [AW-1:0]            offset_q;
    logic [KW-1:0]                   k_q;
    logic                            filling;
    logic                            neg_valid;
    delay_word_t                     pos_delay;
    delay_word_t                     neg_delay;
    delay_bounds_t                   bounds_next;

    function automatic delay_word_t sat_zero(input logic signed [AW-1:0] v);
        if (v < 0) begin
            return '0;
        end
        return v[`BTX_DW_DELAY-1:0];
    endfunction

    // 16.234375 = 16 + 1/4 - 1/64 with two guard bits dropped at the end
    assign n0_full = ((AW'(cfg.r_0) << 10) + (AW'(cfg.r_0) << 4) - AW'(cfg.r_0)) >> 2;

    assign pos_delay = sat_zero(signed'(AW'(n0_q)) + offset_q);
    assign neg_delay = sat_zero(signed'(AW'(n0_q)) - offset_q);
    assign neg_valid = (k_q < KW'(`BTX_HALF_ELEMENTS));   // Last pair has no negative side

    always_comb begin
        bounds_next = bounds;
        if (pos_delay < bounds_next.min_delay) begin
            bounds_next.min_delay = pos_delay;
        end
        if (pos_delay > bounds_next.max_delay) begin
            bounds_next.max_delay = pos_delay;
        end
        if (neg_valid) begin
            if (neg_delay < bounds_next.min_delay) begin
                bounds_next.min_delay = neg_delay;
            end
            if (neg_delay > bounds_next.max_delay) begin
                bounds_next.max_delay = neg_delay;
            end
        end
    end

    // Delay array and bounds
    always_ff @(posedge clk) begin
        if (calc_start) begin
            n0_q             <= n0_full[`BTX_DW_DELAY-1:0];
            step_q           <= cfg.step;
            offset_q         <= AW'(signed'(cfg.step));
            delays[CENTRE]   <= n0_full[`BTX_DW_DELAY-1:0];
            bounds.min_delay <= n0_full[`BTX_DW_DELAY-1:0];
            bounds.max_delay <= n0_full[`BTX_DW_DELAY-1:0];
        end else if (filling) begin
            delays[CENTRE + int'(k_q)] <= pos_delay;
            if (neg_valid) begin
                delays[CENTRE - int'(k_q)] <= neg_delay;
            end
            bounds   <= bounds_next;
            offset_q <= offset_q + AW'(step_q);
        end
    end

    // One pair per cycle outward from the centre
    always_ff @(posedge clk) begin
        if (rst) begin
            filling   <= 1'b0;
            k_q       <= '0;
            calc_done <= 1'b0;
        end else begin
            calc_done <= 1'b0;
            if (calc_start) begin
                filling <= 1'b1;
                k_q     <= KW'(1);
            end else if (filling) begin
                k_q <= k_q + 1'b1;
                if (k_q == KW'(`BTX_HALF_ELEMENTS)) begin
                    filling   <= 1'b0;
                    calc_done <= 1'b1;
                end
            end
        end
    end

endmodule

// File: design/countdown_tx.sv
`timescale 1ns/1ns
`include "beam_tx_macros.svh"

module countdown_tx (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          tx_start,
    input  beam_tx_pkg::delay_array_t     delays,
    input  beam_tx_pkg::delay_bounds_t    bounds,
    output logic [`BTX_NUM_ELEMENTS-1:0]  tx_array,
    output logic                          tx_done
);

    import beam_tx_pkg::*;

    localparam int CW = `BTX_DW_DELAY - `BTX_DW_FRAC;

    logic                          running;
    logic [CW-1:0]                 count;
    logic [CW-1:0]                 span;
    delay_word_t                   span_full;
    logic [`BTX_NUM_ELEMENTS-1:0]  hit;

    assign span_full = bounds.max_delay - bounds.min_delay;
    assign span      = span_full[`BTX_DW_DELAY-1:`BTX_DW_FRAC];

    // Integer offset of each element from the earliest one
    always_comb begin
        delay_word_t rel;
        for (int i = 0; i < `BTX_NUM_ELEMENTS; i++) begin
            rel    = delays[i] - bounds.min_delay;
            hit[i] = (rel[`BTX_DW_DELAY-1:`BTX_DW_FRAC] == count);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            running  <= 1'b0;
            count    <= '0;
            tx_array <= '0;
            tx_done  <= 1'b0;
        end else begin
            tx_array <= running ? hit : '0;
            tx_done  <= running && (count == span);   // Aligned with the last pulses
            if (tx_start) begin
                running <= 1'b1;
                count   <= '0;
            end else if (running) begin
                count <= count + 1'b1;
                if (count == span) begin
                    running <= 1'b0;
                end
            end
        end
    end

endmodule

// File: design/beam_tx_top.sv
`timescale 1ns/1ns
`include "beam_tx_macros.svh"

module beam_tx_top (
    input  logic                          clk,
    input  logic                          rst,
    input  beam_tx_pkg::apb_req_t         apb_req,
    output beam_tx_pkg::apb_rsp_t         apb_rsp,
    output logic [`BTX_NUM_ELEMENTS-1:0]  tx_array,
    output logic                          scan_done
);

    import beam_tx_pkg::*;

    scan_cfg_t      cfg;
    logic           start;
    logic           busy;
    logic           calc_start;
    logic           calc_done;
    logic           tx_start;
    logic           tx_done;
    delay_array_t   delays;
    delay_bounds_t  bounds;

    apb_cfg_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .apb_req   (apb_req),
        .busy      (busy),
        .scan_done (scan_done),
        .apb_rsp   (apb_rsp),
        .cfg       (cfg),
        .start     (start)
    );

    scan_sequencer u_seq (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .start      (start),
        .calc_done  (calc_done),
        .tx_done    (tx_done),
        .calc_start (calc_start),
        .tx_start   (tx_start),
        .busy       (busy),
        .scan_done  (scan_done)
    );

    delay_calc u_calc (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .calc_start (calc_start),
        .delays     (delays),
        .bounds     (bounds),
        .calc_done  (calc_done)
    );

    countdown_tx u_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_start (tx_start),
        .delays   (delays),
        .bounds   (bounds),
        .tx_array (tx_array),
        .tx_done  (tx_done)
    );

endmodule

// File: tests/tb_beam_tx.sv
`timescale 1ns/1ns
`include "beam_tx_macros.svh"

module tb_beam_tx;

    import beam_tx_pkg::*;

    localparam int NUM_EL     = `BTX_NUM_ELEMENTS;
    localparam int TX_CYCLES  = 9 + 130 + `BTX_TX_GAP;   // Calc, widest span, gap
    localparam int MAX_CYCLES = 6 * 3 * TX_CYCLES + 1000;

    logic                clk;
    logic                rst;
    apb_req_t            apb_req;
    apb_rsp_t            apb_rsp;
    logic [NUM_EL-1:0]   tx_array;
    logic                scan_done;

    int                  cycles = 0;
    int                  errors = 0;
    int                  test_base;
    int                  tests_failed = 0;
    int                  tx_count = 0;
    int                  done_count = 0;
    int                  tx_base;
    int                  done_base;
    logic                tx_open = 1'b0;
    logic [NUM_EL-1:0]   seen;
    int                  first_cycle;
    int                  last_span;
    int                  pulse_off [NUM_EL];
    int                  exp_off [NUM_EL];

    beam_tx_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .tx_array  (tx_array),
        .scan_done (scan_done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cycles <= cycles + 1;

    initial begin
        while (cycles < MAX_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, the scan never finished", cycles);
        $display("Test FAILED");
        $finish;
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    // One transmission closes once every element has fired
    always @(negedge clk) begin
        if (scan_done) begin
            done_count++;
            assert (!tx_open) else begin
                $display("Scan ended while some elements had not pulsed");
                errors++;
            end
        end
        if (tx_array != '0) begin
            if (!tx_open) begin
                tx_open     = 1'b1;
                first_cycle = cycles;
                seen        = '0;
            end
            for (int i = 0; i < NUM_EL; i++) begin
                if (tx_array[i]) begin
                    assert (!seen[i]) else begin
                        $display("Element %0d pulsed twice in one transmission", i);
                        errors++;
                    end
                    seen[i]      = 1'b1;
                    pulse_off[i] = cycles - first_cycle;
                end
            end
            if (&seen) begin
                tx_open   = 1'b0;
                last_span = cycles - first_cycle;
                tx_count++;
                for (int i = 0; i < NUM_EL; i++) begin
                    check_val($sformatf("tx_array[%0d] offset", i), 32'(pulse_off[i]),
                              32'(exp_off[i]));
                end
            end
        end
    end

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
        @(posedge clk);
        #2;
        apb_req        = '0;
        apb_req.psel   = 1'b1;
        apb_req.pwrite = 1'b1;
        apb_req.paddr  = addr;
        apb_req.pwdata = data;
        @(posedge clk);
        #2;
        apb_req.penable = 1'b1;
        @(negedge clk);
        err = apb_rsp.pslverr;
        check_val("pready", 32'(apb_rsp.pready), 32'h1);
        @(posedge clk);
        #2;
        apb_req = '0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
        @(posedge clk);
        #2;
        apb_req       = '0;
        apb_req.psel  = 1'b1;
        apb_req.paddr = addr;
        @(posedge clk);
        #2;
        apb_req.penable = 1'b1;
        @(negedge clk);
        data = apb_rsp.prdata;
        err  = apb_rsp.pslverr;
        check_val("pready", 32'(apb_rsp.pready), 32'h1);
        @(posedge clk);
        #2;
        apb_req = '0;
    endtask

    // Expected pulse offsets from linear delays around the centre element
    task automatic build_model(input logic [7:0] r0, input logic signed [7:0] step);
        int n0;
        int d [NUM_EL];
        int dmin;
        n0   = (int'(r0) * 1039) / 4;   // 16.234375 * 16 per unit of r_0
        dmin = n0;
        for (int i = 0; i < NUM_EL; i++) begin
            d[i] = n0 + int'(step) * (i - (`BTX_HALF_ELEMENTS - 1));
            if (d[i] < 0) d[i] = 0;
            if (d[i] < dmin) dmin = d[i];
        end
        for (int i = 0; i < NUM_EL; i++) begin
            exp_off[i] = (d[i] - dmin) >> `BTX_DW_FRAC;
        end
    endtask

    task automatic start_scan(input logic [7:0] r0, input logic signed [7:0] step,
                              input int points);
        logic err;
        apb_write(`BTX_ADDR_CFG, {16'h0, step, r0}, err);
        apb_write(`BTX_ADDR_POINTS, 32'(points), err);
        build_model(r0, step);
        tx_base   = tx_count;
        done_base = done_count;
        apb_write(`BTX_ADDR_CTRL, 32'h1, err);
    endtask

    task automatic finish_scan(input int points);
        while (done_count == done_base) @(posedge clk);
        repeat (`BTX_TX_GAP + 4) @(posedge clk);   // Room for a stray pulse
        check_val("transmissions", 32'(tx_count - tx_base), 32'((points == 0) ? 1 : points));
        check_val("scan_done pulses", 32'(done_count - done_base), 32'h1);
    endtask

    task automatic end_test(input int num, input string name);
        if (errors == test_base) begin
            $display("test %0d %s: passed", num, name);
        end else begin
            $display("test %0d %s: failed with %0d errors", num, name, errors - test_base);
            tests_failed++;
        end
        test_base = errors;
    endtask

    initial begin
        logic [31:0] rdata;
        logic        err;
        logic [7:0]  r0;
        logic [7:0]  step;
        int          zeros;
        int          exp_zeros;
        rst     = 1'b1;
        apb_req = '0;
        void'($urandom(18));
        repeat (3) @(posedge clk);
        #2;
        rst       = 1'b0;
        test_base = 0;

        // Register access
        apb_read(`BTX_ADDR_STATUS, rdata, err);
        check_val("STATUS", rdata, 32'h0);
        apb_write(`BTX_ADDR_CFG, 32'h0000_A53C, err);
        apb_read(`BTX_ADDR_CFG, rdata, err);
        check_val("CFG", rdata, 32'h0000_A53C);
        check_val("pslverr", 32'(err), 32'h0);
        apb_write(`BTX_ADDR_POINTS, 32'h0000_1ABC, err);
        apb_read(`BTX_ADDR_POINTS, rdata, err);
        check_val("POINTS", rdata, 32'h0000_1ABC);
        apb_read(4'h2, rdata, err);
        check_val("pslverr", 32'(err), 32'h1);
        apb_write(4'hE, 32'h1, err);
        check_val("pslverr", 32'(err), 32'h1);
        end_test(1, "register access");

        // Random r_0 with a positive then a negative step
        r0   = 8'($urandom % 255 + 1);
        step = 8'($urandom % 127 + 1);
        start_scan(r0, step, 1);
        finish_scan(1);
        r0   = 8'($urandom % 255 + 1);
        step = 8'(-int'($urandom % 128 + 1));
        start_scan(r0, step, 1);
        finish_scan(1);
        end_test(2, "steered pulses");

        // No steering
        start_scan(8'd100, 8'sd0, 1);
        finish_scan(1);
        check_val("pulse spread", 32'(last_span), 32'h0);
        end_test(3, "zero step");

        // Negative side clamps to zero
        start_scan(8'd2, -8'sd128, 1);
        finish_scan(1);
        zeros     = 0;
        exp_zeros = 0;
        for (int i = 0; i < NUM_EL; i++) begin
            if (pulse_off[i] == 0) begin
                zeros++;
            end
            if (exp_off[i] == 0) begin
                exp_zeros++;
            end
        end
        check_val("elements at offset zero", 32'(zeros), 32'(exp_zeros));
        end_test(4, "saturation");

        // Three points
        start_scan(8'd57, 8'sd45, 3);
        finish_scan(3);
        apb_read(`BTX_ADDR_STATUS, rdata, err);
        check_val("STATUS", rdata, 32'h2);
        end_test(5, "three points");

        // Start while busy is ignored
        start_scan(8'd200, -8'sd30, 3);
        while (tx_count == tx_base) @(posedge clk);
        apb_write(`BTX_ADDR_CTRL, 32'h1, err);
        finish_scan(3);
        repeat (40) @(posedge clk);
        check_val("transmissions", 32'(tx_count - tx_base), 32'h3);
        apb_read(`BTX_ADDR_STATUS, rdata, err);
        check_val("STATUS", rdata, 32'h2);
        end_test(6, "start while busy");

        $display("tests 6, passed %0d, failed %0d, errors %0d",
                 6 - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+design
design/beam_tx_pkg.sv
design/apb_cfg_regs.sv
design/scan_sequencer.sv
design/delay_calc.sv
design/countdown_tx.sv
design/beam_tx_top.sv
tests/tb_beam_tx.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_beam_tx
FLIST     = flist.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
